// ==== hw/irq_latch.sv ====
`timescale 1ns/1ps

module irq_latch import xdig_pkg::*; (
   input  logic      clk,
   input  logic      RST,
   input  chan_vec_t event_i,   // channel trigger pulses
   input  chan_vec_t mask_i,
   input  logic      rst_i,     // clears every channel
   input  chan_vec_t clr_i,
   output chan_vec_t irq_o,
   output logic      irq_n_o
);

   chan_vec_t set_v;
   chan_vec_t clr_v;

   assign set_v = event_i & mask_i;
   assign clr_v = clr_i | {4{rst_i}};

   // set/clear per channel, clearing has priority
   always_ff @(posedge clk) begin
      if (RST)
         irq_o <= '0;
      else
         irq_o <= (irq_o | set_v) & ~clr_v;
   end

   assign irq_n_o = ~|irq_o;   // any latched bit pulls the line low

endmodule

// ==== hw/multiboot_seq.sv ====
`timescale 1ns/1ps
`include "xdig_defines.svh"

module multiboot_seq import xdig_pkg::*; (
   input  logic       clk,
   input  logic       RST,
   input  logic       start_i,
   output logic       icap_ce_n_o,
   output logic       icap_clk_o,
   output logic [7:0] icap_data_o
);

   icap_state_t state;
   logic [3:0]  word;
   logic [7:0]  byte_v;

   // reboot command stream
   always_comb begin
      case (word)
         4'd2:    byte_v = 8'haa;   // sync word
         4'd3:    byte_v = 8'h99;
         4'd4:    byte_v = 8'h30;   // type 1 write
         4'd5:    byte_v = 8'ha1;
         4'd6:    byte_v = 8'h00;   // reboot
         4'd7:    byte_v = 8'h0e;
         4'd8:    byte_v = 8'h20;   // nop
         default: byte_v = 8'h00;   // leading dummies and trailing nops
      endcase
   end

   // config port takes bit 0 on its msb
   always_comb begin
      for (int i = 0; i < 8; i++)
         icap_data_o[7-i] = byte_v[i];
   end

   // ------------------------------
   // sequencer FSM
   // ------------------------------
   always_ff @(posedge clk) begin
      if (RST) begin
         state       <= ICAP_IDLE;
         word        <= '0;
         icap_ce_n_o <= 1'b1;
         icap_clk_o  <= 1'b0;
      end else begin
         case (state)
            ICAP_IDLE: begin
               word <= '0;
               if (start_i) begin
                  icap_ce_n_o <= 1'b0;
                  state       <= ICAP_START;
               end
            end
            ICAP_START:    state <= ICAP_CLK_RISE;
            ICAP_CLK_RISE: begin
               icap_clk_o <= 1'b1;
               state      <= ICAP_CLK_FALL;
            end
            ICAP_CLK_FALL: begin
               icap_clk_o <= 1'b0;
               state      <= ICAP_DATA_CHANGE;
            end
            ICAP_DATA_CHANGE: begin
               if (word == 4'(`XDIG_ICAP_WORDS - 1)) begin
                  icap_ce_n_o <= 1'b1;   // last byte done
                  state       <= ICAP_IDLE;
               end else begin
                  word  <= word + 1'b1;
                  state <= ICAP_CLK_RISE;
               end
            end
            default: state <= ICAP_IDLE;
         endcase
      end
   end

endmodule

// ==== hw/pulse_gen.sv ====
`timescale 1ns/1ps
`include "xdig_defines.svh"

module pulse_gen import xdig_pkg::*; (
   input  logic        clk,
   input  logic        RST,
   input  gen_period_t period_i,
   output logic        gen_o
);

   localparam int PRE_W = $clog2(`XDIG_TICK_CYCLES + 1);

   logic [PRE_W-1:0] presc;
   logic             tick;
   gen_period_t      count;

   assign tick = (presc == '0);

   always_ff @(posedge clk) begin
      if (RST) begin
         presc <= '0;
         count <= '0;
         gen_o <= 1'b0;
      end else begin
         presc <= tick ? PRE_W'(`XDIG_TICK_CYCLES - 1) : presc - 1'b1;
         if (tick) begin
            if (count == 8'd5)
               gen_o <= 1'b1;
            else if (count == 8'd0)
               gen_o <= 1'b0;
            if (count == 8'd0) begin
               if (period_i > 8'd4)   // short periods park the counter
                  count <= period_i;
            end else begin
               count <= count - 1'b1;
            end
         end
      end
   end

endmodule

// ==== hw/sync_select.sv ====
`timescale 1ns/1ps

module sync_select import xdig_pkg::*; (
   input  sync_sel_t sel_i,
   input  logic      gen_i,
   input  logic      mcu_trigin_i,
   input  chan_vec_t trig_i,
   input  logic      sync_in_i,
   input  logic      mcu_sync_i,
   output logic      sync_o
);

   always_comb begin
      case (sel_i)
         5'd1:    sync_o = gen_i;
         5'd3:    sync_o = mcu_trigin_i;   // composite trigger flag
         5'd4:    sync_o = trig_i[0];
         5'd5:    sync_o = trig_i[1];
         5'd6:    sync_o = trig_i[2];
         5'd7:    sync_o = trig_i[3];
         5'd24:   sync_o = sync_in_i;      // external loop-through
         default: sync_o = mcu_sync_i;
      endcase
   end

endmodule

// ==== hw/trig_filter.sv ====
`timescale 1ns/1ps

module trig_filter import xdig_pkg::*; (
   input  logic      clk,
   input  logic      RST,
   input  logic      trig_n_i,      // active low pin
   input  reg_word_t filter_len_i,
   output logic      trig_o
);

   logic      trig;
   reg_word_t cnt;   // cycles the input has disagreed with trig_o

   assign trig = ~trig_n_i;

   always_ff @(posedge clk) begin
      if (RST) begin
         cnt    <= '0;
         trig_o <= 1'b0;
      end else if (trig == trig_o) begin
         cnt <= '0;                  // glitch over, start again
      end else if (cnt == filter_len_i) begin
         trig_o <= trig;             // held long enough
         cnt    <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

endmodule

// ==== hw/trig_router.sv ====
`timescale 1ns/1ps

module trig_router import xdig_pkg::*; (
   input  logic      clk,
   input  logic      RST,
   input  src_vec_t  src_i,         // filtered inputs plus generator
   input  trig_src_t trig_src_i,
   input  chan_vec_t man_trig_i,
   output chan_vec_t trig_o,
   output ant_sel_t  ant_sel_o,
   output logic      mcu_trigin_o
);

   src_vec_t  src_dly;
   src_vec_t  rising;
   src_vec_t  falling;
   ant_sel_t  ant_code;
   chan_vec_t fall_sel;
   chan_vec_t rise_sel;

   // edge of the source picked by one channel's select code
   function automatic logic pick_edge(trig_sel_t sel, src_vec_t edges);
      logic hit;
      case (sel)
         4'd1:    hit = edges[0];
         4'd2:    hit = edges[1];
         4'd3:    hit = edges[2];
         4'd4:    hit = edges[3];
         4'd5:    hit = edges[4];   // generator
         default: hit = 1'b0;       // manual only
      endcase
      return hit;
   endfunction

   assign rising  = src_i & ~src_dly;
   assign falling = ~src_i & src_dly;

   // ------------------------------
   // antenna decode
   // ------------------------------
   always_comb begin
      case (rising)
         5'b00001: ant_code = 3'd0;
         5'b00010: ant_code = 3'd1;
         5'b00100: ant_code = 3'd2;
         5'b01000: ant_code = 3'd3;
         5'b10000: ant_code = 3'd5;
         default:  ant_code = 3'd7;   // several at once
      endcase
   end

   always_comb begin
      for (int n = 0; n < 4; n++) begin
         fall_sel[n] = pick_edge(trig_src_i[4*n +: 4], falling);
         rise_sel[n] = pick_edge(trig_src_i[4*n +: 4], rising);
      end
   end

   // ------------------------------
   // registered outputs
   // ------------------------------
   always_ff @(posedge clk) begin
      if (RST) begin
         src_dly      <= '0;
         trig_o       <= '0;
         ant_sel_o    <= 3'd7;
         mcu_trigin_o <= 1'b0;
      end else begin
         src_dly <= src_i;
         trig_o  <= man_trig_i | fall_sel;   // single-cycle pulses
         if (|rising)
            ant_sel_o <= ant_code;
         if (|fall_sel)
            mcu_trigin_o <= 1'b0;            // clear wins
         else if (|rise_sel)
            mcu_trigin_o <= 1'b1;
      end
   end

endmodule

// ==== hw/xdig.sv ====
`timescale 1ns/1ps

module xdig import xdig_pkg::*; (
   input  logic       clk,
   input  logic       RST,
   // register bus
   input  reg_addr_t  addr_i,
   input  reg_word_t  wdata_i,
   input  logic       we_i,
   output reg_word_t  rdata_o,
   // trigger and sync pins
   input  chan_vec_t  trig_n_i,
   input  logic       sync_in_i,
   input  logic       mcu_sync_i,
   output ant_sel_t   ant_sel_o,
   output logic       mcu_trigin_o,
   output logic       sync_o,
   output logic       irq_n_o,
   // configuration port
   output logic       icap_ce_n_o,
   output logic       icap_clk_o,
   output logic [7:0] icap_data_o
);

   trig_src_t   trig_src;
   reg_word_t   filter_len;
   gen_period_t gen_period;
   sync_sel_t   sync_sel;
   chan_vec_t   irq_mask;
   chan_vec_t   man_trig;
   logic        irq_rst;
   chan_vec_t   irq_clr;
   logic        mb_start;
   chan_vec_t   irq;
   chan_vec_t   trig_flt;
   logic        gen;
   chan_vec_t   trig;

   xdig_regs regs_i (
      .clk(clk), .RST(RST), .addr_i(addr_i), .wdata_i(wdata_i), .we_i(we_i),
      .irq_i(irq), .rdata_o(rdata_o), .trig_src_o(trig_src),
      .filter_len_o(filter_len), .gen_period_o(gen_period), .sync_sel_o(sync_sel),
      .irq_mask_o(irq_mask), .man_trig_o(man_trig), .irq_rst_o(irq_rst),
      .irq_clr_o(irq_clr), .mb_start_o(mb_start)
   );

   // one filter per trigger pin
   for (genvar n = 0; n < 4; n++) begin : g_filter
      trig_filter filter_i (
         .clk(clk), .RST(RST), .trig_n_i(trig_n_i[n]),
         .filter_len_i(filter_len), .trig_o(trig_flt[n])
      );
   end

   pulse_gen gen_i (
      .clk(clk), .RST(RST), .period_i(gen_period), .gen_o(gen)
   );

   trig_router router_i (
      .clk(clk), .RST(RST), .src_i({gen, trig_flt}), .trig_src_i(trig_src),
      .man_trig_i(man_trig), .trig_o(trig), .ant_sel_o(ant_sel_o),
      .mcu_trigin_o(mcu_trigin_o)
   );

   irq_latch irq_i (
      .clk(clk), .RST(RST), .event_i(trig), .mask_i(irq_mask), .rst_i(irq_rst),
      .clr_i(irq_clr), .irq_o(irq), .irq_n_o(irq_n_o)
   );

   sync_select sync_i (
      .sel_i(sync_sel), .gen_i(gen), .mcu_trigin_i(mcu_trigin_o), .trig_i(trig),
      .sync_in_i(sync_in_i), .mcu_sync_i(mcu_sync_i), .sync_o(sync_o)
   );

   multiboot_seq mboot_i (
      .clk(clk), .RST(RST), .start_i(mb_start), .icap_ce_n_o(icap_ce_n_o),
      .icap_clk_o(icap_clk_o), .icap_data_o(icap_data_o)
   );

endmodule

// ==== hw/xdig_defines.svh ====
`ifndef XDIG_DEFINES_SVH
`define XDIG_DEFINES_SVH

// register map, 4-bit word addresses
`define XDIG_ADDR_VERSION   4'd0
`define XDIG_ADDR_CTRL      4'd1   // write only, strobes
`define XDIG_ADDR_TRIG_SRC  4'd2
`define XDIG_ADDR_FILTER    4'd3
`define XDIG_ADDR_GEN       4'd4
`define XDIG_ADDR_SYNC      4'd5
`define XDIG_ADDR_IRQ_MASK  4'd6
`define XDIG_ADDR_IRQ_CLR   4'd7   // write only, strobes
`define XDIG_ADDR_IRQ       4'd8   // read only
`define XDIG_ADDR_MULTIBOOT 4'd9   // write only, strobe

`define XDIG_VERSION        16'h0110

// clk cycles per generator tick, kept short for simulation
`define XDIG_TICK_CYCLES    8
// bytes in the reboot command sequence
`define XDIG_ICAP_WORDS     12

`endif

// ==== hw/xdig_pkg.sv ====
package xdig_pkg;

   typedef logic [15:0] reg_word_t;    // register and bus word
   typedef logic [3:0]  reg_addr_t;

   typedef logic [3:0]  chan_vec_t;    // one bit per RF channel
   typedef logic [4:0]  src_vec_t;     // inputs 1-4 in bits 3:0, generator in bit 4

   // 0 manual only, 1-4 trigger input, 5 generator
   typedef logic [3:0]  trig_sel_t;
   // channel n in bits 4n-1:4n-4
   typedef logic [15:0] trig_src_t;

   typedef logic [2:0]  ant_sel_t;
   typedef logic [4:0]  sync_sel_t;
   typedef logic [7:0]  gen_period_t;  // in generator ticks

   // reboot sequencer
   typedef enum logic [2:0] {
      ICAP_IDLE,
      ICAP_START,
      ICAP_CLK_RISE,
      ICAP_CLK_FALL,
      ICAP_DATA_CHANGE
   } icap_state_t;

endpackage

// ==== hw/xdig_regs.sv ====
`timescale 1ns/1ps
`include "xdig_defines.svh"

module xdig_regs import xdig_pkg::*; (
   input  logic        clk,
   input  logic        RST,
   input  reg_addr_t   addr_i,
   input  reg_word_t   wdata_i,
   input  logic        we_i,
   input  chan_vec_t   irq_i,         // latched interrupts for readback
   output reg_word_t   rdata_o,
   output trig_src_t   trig_src_o,
   output reg_word_t   filter_len_o,
   output gen_period_t gen_period_o,
   output sync_sel_t   sync_sel_o,
   output chan_vec_t   irq_mask_o,
   output chan_vec_t   man_trig_o,
   output logic        irq_rst_o,
   output chan_vec_t   irq_clr_o,
   output logic        mb_start_o
);

   // ------------------------------
   // configuration registers
   // ------------------------------
   always_ff @(posedge clk) begin
      if (RST) begin
         trig_src_o   <= '0;
         filter_len_o <= '0;
         gen_period_o <= '0;
         sync_sel_o   <= '0;
         irq_mask_o   <= '0;
      end else if (we_i) begin
         case (addr_i)
            `XDIG_ADDR_TRIG_SRC: trig_src_o   <= wdata_i;
            `XDIG_ADDR_FILTER:   filter_len_o <= wdata_i;
            `XDIG_ADDR_GEN:      gen_period_o <= wdata_i[7:0];
            `XDIG_ADDR_SYNC:     sync_sel_o   <= wdata_i[4:0];
            `XDIG_ADDR_IRQ_MASK: irq_mask_o   <= wdata_i[3:0];
            default: ;
         endcase
      end
   end

   // ------------------------------
   // command strobes, one cycle
   // ------------------------------
   always_ff @(posedge clk) begin
      if (RST) begin
         man_trig_o <= '0;
         irq_rst_o  <= 1'b0;
         irq_clr_o  <= '0;
         mb_start_o <= 1'b0;
      end else begin
         man_trig_o <= '0;
         irq_rst_o  <= 1'b0;
         irq_clr_o  <= '0;
         mb_start_o <= 1'b0;
         if (we_i) begin
            case (addr_i)
               `XDIG_ADDR_CTRL: begin
                  man_trig_o <= wdata_i[11:8];   // manual channel triggers
                  irq_rst_o  <= wdata_i[15];
               end
               `XDIG_ADDR_IRQ_CLR:   irq_clr_o  <= wdata_i[3:0];
               `XDIG_ADDR_MULTIBOOT: mb_start_o <= wdata_i[0];
               default: ;
            endcase
         end
      end
   end

   // read mux
   always_comb begin
      case (addr_i)
         `XDIG_ADDR_VERSION:  rdata_o = `XDIG_VERSION;
         `XDIG_ADDR_TRIG_SRC: rdata_o = trig_src_o;
         `XDIG_ADDR_FILTER:   rdata_o = filter_len_o;
         `XDIG_ADDR_GEN:      rdata_o = {8'b0, gen_period_o};
         `XDIG_ADDR_SYNC:     rdata_o = {11'b0, sync_sel_o};
         `XDIG_ADDR_IRQ_MASK: rdata_o = {12'b0, irq_mask_o};
         `XDIG_ADDR_IRQ:      rdata_o = {12'b0, irq_i};
         default:             rdata_o = '0;   // write-only and unused
      endcase
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the xdig testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module tb_xdig -f xdig.f
./obj_dir/Vtb_xdig | tee sim.log

# pass only if the testbench printed its pass message
grep -q "ALL CHECKS PASSED" sim.log

// ==== tests/tb_xdig_tasks.svh ====
// ------------------------------
// bus access
// ------------------------------
task automatic wait_cycles(input int n);
   repeat (n) @(negedge clk);
endtask

task automatic bus_write(input reg_addr_t a, input reg_word_t d);
   @(negedge clk);
   addr_i  = a;
   wdata_i = d;
   we_i    = 1'b1;
   @(negedge clk);   // write lands on the edge in between
   we_i = 1'b0;
endtask

task automatic bus_read(input reg_addr_t a, output reg_word_t d);
   @(negedge clk);
   addr_i = a;
   @(negedge clk);
   d = rdata_o;
endtask

// ------------------------------
// checkers
// ------------------------------
task automatic check_eq(input string name, input reg_word_t got, input reg_word_t exp);
   assert (got === exp) begin
      pass_cnt++;
   end else begin
      fail_cnt++;
      test_fails++;
      $display("error %s: got %h, expected %h", name, got, exp);
   end
endtask

task automatic check_true(input logic ok, input string what);
   assert (ok) begin
      pass_cnt++;
   end else begin
      fail_cnt++;
      test_fails++;
      $display("%s", what);
   end
endtask

task automatic read_check(input reg_addr_t a, input reg_word_t exp);
   reg_word_t rd;
   bus_read(a, rd);
   check_eq("rdata_o", rd, exp);
endtask

task automatic end_test(input string name);
   if (test_fails == 0)
      $display("test %s: ok", name);
   else
      $display("test %s: %0d mismatches", name, test_fails);
   test_fails = 0;
endtask

// ------------------------------
// stimulus and reference values
// ------------------------------
function automatic chan_vec_t pin_of(input int n);   // input n is pin bit n-1
   return chan_vec_t'(1 << (n - 1));
endfunction

// low pulse on the selected pins, width in clk cycles
task automatic pin_pulse(input chan_vec_t pins, input int width);
   @(negedge clk);
   trig_n_i = ~pins;
   repeat (width) @(negedge clk);
   trig_n_i = 4'hf;
endtask

task automatic set_sync_pins(input logic s, input logic m);
   sync_in_i  = s;
   mcu_sync_i = m;
   wait_cycles(1);
endtask

// readable bits of each writable register
function automatic reg_word_t field_mask(input int a);
   case (a)
      4:       return 16'h00ff;
      5:       return 16'h001f;
      6:       return 16'h000f;
      default: return 16'hffff;
   endcase
endfunction

// reboot command bytes in send order
function automatic logic [7:0] boot_byte(input int i);
   case (i)
      2:       return 8'haa;
      3:       return 8'h99;
      4:       return 8'h30;
      5:       return 8'ha1;
      7:       return 8'h0e;
      8:       return 8'h20;
      default: return 8'h00;
   endcase
endfunction

function automatic logic [7:0] bit_reverse(input logic [7:0] b);
   return {<<{b}};
endfunction

// ==== tests/tb_xdig.sv ====
`timescale 1ns/1ps
`include "xdig_defines.svh"

module tb_xdig import xdig_pkg::*; ();

   localparam int CLK_PERIOD = 4;
   localparam int RST_CYCLES = 16;
   // worst case cycles per test, filter length at most 9
   localparam int RUN_CYCLES = RST_CYCLES + 80 + 240 + 260 + 80 + 240 + 60;

   logic       clk;
   logic       RST;
   reg_addr_t  addr_i;
   reg_word_t  wdata_i;
   logic       we_i;
   reg_word_t  rdata_o;
   chan_vec_t  trig_n_i;
   logic       sync_in_i;
   logic       mcu_sync_i;
   ant_sel_t   ant_sel_o;
   logic       mcu_trigin_o;
   logic       sync_o;
   logic       irq_n_o;
   logic       icap_ce_n_o;
   logic       icap_clk_o;
   logic [7:0] icap_data_o;

   int seed = 32'h65e4;
   int pass_cnt = 0;
   int fail_cnt = 0;
   int test_fails = 0;
   int flt;   // programmed filter length

   `include "tb_xdig_tasks.svh"

   xdig xdig_i (
      .clk(clk), .RST(RST), .addr_i(addr_i), .wdata_i(wdata_i), .we_i(we_i),
      .rdata_o(rdata_o), .trig_n_i(trig_n_i), .sync_in_i(sync_in_i),
      .mcu_sync_i(mcu_sync_i), .ant_sel_o(ant_sel_o), .mcu_trigin_o(mcu_trigin_o),
      .sync_o(sync_o), .irq_n_o(irq_n_o), .icap_ce_n_o(icap_ce_n_o),
      .icap_clk_o(icap_clk_o), .icap_data_o(icap_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // config port clock only runs while enabled
   always @(negedge clk) begin
      if (!RST) begin
         assert (!(icap_ce_n_o && icap_clk_o)) else begin
            fail_cnt++;
            $display("icap_clk_o was high while icap_ce_n_o was high");
         end
      end
   end

   initial begin
      #(RUN_CYCLES * 2 * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      reg_word_t wv;
      int        width;
      int        n;
      int        k;
      int        other;
      int        third;
      int        cyc;
      int        high_len;
      int        low_len;
      int        nbytes;
      logic      prev_clk;

      addr_i     = '0;
      wdata_i    = '0;
      we_i       = 1'b0;
      trig_n_i   = 4'hf;
      sync_in_i  = 1'b0;
      mcu_sync_i = 1'b0;
      RST        = 1'b1;
      repeat (RST_CYCLES) @(negedge clk);
      RST = 1'b0;

      // ------------------------------
      // register file
      // ------------------------------
      read_check(`XDIG_ADDR_VERSION, `XDIG_VERSION);
      for (int a = 1; a < 16; a++)
         read_check(reg_addr_t'(a), '0);
      for (int a = 2; a <= 6; a++) begin
         wv = reg_word_t'($random(seed));
         if (a == 4)
            wv[7:2] = 6'b0;   // keep the generator parked
         bus_write(reg_addr_t'(a), wv);
         read_check(reg_addr_t'(a), wv & field_mask(a));
      end
      for (int a = 2; a <= 6; a++)
         bus_write(reg_addr_t'(a), '0);
      end_test("registers");

      // ------------------------------
      // filter and antenna select
      // ------------------------------
      flt = 2 + ({$random(seed)} % 8);
      bus_write(`XDIG_ADDR_FILTER, reg_word_t'(flt));
      for (n = 1; n <= 4; n++) begin
         width = 1 + ({$random(seed)} % flt);   // always too short to pass
         pin_pulse(pin_of(n), width);
         wait_cycles(flt + 4);
         check_eq("ant_sel_o", {13'b0, ant_sel_o}, 16'h7);
      end
      for (n = 1; n <= 4; n++) begin
         pin_pulse(pin_of(n), flt + 4);
         check_eq("ant_sel_o", {13'b0, ant_sel_o}, reg_word_t'(n - 1));
         wait_cycles(flt + 4);
      end
      pin_pulse(4'b0011, flt + 4);   // two inputs at once
      check_eq("ant_sel_o", {13'b0, ant_sel_o}, 16'h7);
      wait_cycles(flt + 4);
      end_test("filter_antenna");

      // channel k on input 4-k, a masked neighbour on the same input
      // and an unmasked channel on another input
      for (k = 0; k < 4; k++) begin
         n = 4 - k;
         other = (k + 1) % 4;
         third = (k + 2) % 4;
         wv = reg_word_t'((n << (4 * k)) | (n << (4 * other)));
         wv |= reg_word_t'((n % 4 + 1) << (4 * third));   // not the pulsed input
         bus_write(`XDIG_ADDR_TRIG_SRC, wv);
         bus_write(`XDIG_ADDR_IRQ_MASK, reg_word_t'((1 << k) | (1 << third)));
         pin_pulse(pin_of(n), flt + 4);
         wait_cycles(flt + 4);
         read_check(`XDIG_ADDR_IRQ, reg_word_t'(1 << k));
         check_eq("irq_n_o", {15'b0, irq_n_o}, 16'h0);
         bus_write(`XDIG_ADDR_IRQ_CLR, reg_word_t'(1 << k));
         read_check(`XDIG_ADDR_IRQ, '0);
         check_eq("irq_n_o", {15'b0, irq_n_o}, 16'h1);
         bus_write(`XDIG_ADDR_CTRL, reg_word_t'((1 << (k + 8)) | (1 << (other + 8))));
         wait_cycles(2);
         read_check(`XDIG_ADDR_IRQ, reg_word_t'(1 << k));
         bus_write(`XDIG_ADDR_CTRL, 16'h8000);   // reset all interrupts
         wait_cycles(1);
         read_check(`XDIG_ADDR_IRQ, '0);
      end
      bus_write(`XDIG_ADDR_IRQ_MASK, '0);
      end_test("triggers_irq");

      // mcu flag follows input 2 only while a channel selects it
      bus_write(`XDIG_ADDR_TRIG_SRC, 16'h0002);
      trig_n_i = ~pin_of(2);
      wait_cycles(flt + 4);
      check_eq("mcu_trigin_o", {15'b0, mcu_trigin_o}, 16'h1);
      trig_n_i = 4'hf;
      wait_cycles(flt + 4);
      check_eq("mcu_trigin_o", {15'b0, mcu_trigin_o}, 16'h0);
      bus_write(`XDIG_ADDR_TRIG_SRC, 16'h0003);
      trig_n_i = ~pin_of(2);
      wait_cycles(flt + 4);
      check_eq("mcu_trigin_o", {15'b0, mcu_trigin_o}, 16'h0);
      trig_n_i = 4'hf;
      wait_cycles(flt + 4);
      check_eq("mcu_trigin_o", {15'b0, mcu_trigin_o}, 16'h0);
      bus_write(`XDIG_ADDR_TRIG_SRC, '0);
      end_test("mcu_flag");

      // ------------------------------
      // generator and sync select
      // ------------------------------
      bus_write(`XDIG_ADDR_SYNC, 16'd1);
      bus_write(`XDIG_ADDR_GEN, 16'd9);
      cyc = 0;
      while (sync_o !== 1'b1 && cyc < 200) begin
         @(negedge clk);
         cyc++;
      end
      check_true(sync_o === 1'b1, "sync_o never went high with the generator selected");
      high_len = 0;
      while (sync_o === 1'b1 && high_len < 200) begin
         @(negedge clk);
         high_len++;
      end
      low_len = 0;
      while (sync_o === 1'b0 && low_len < 200) begin
         @(negedge clk);
         low_len++;
      end
      check_eq("sync_o high cycles", reg_word_t'(high_len), reg_word_t'(5 * `XDIG_TICK_CYCLES));
      check_eq("sync_o period", reg_word_t'(high_len + low_len),
               reg_word_t'(10 * `XDIG_TICK_CYCLES));
      bus_write(`XDIG_ADDR_GEN, '0);
      bus_write(`XDIG_ADDR_SYNC, 16'd24);
      set_sync_pins(1'b1, 1'b0);
      check_eq("sync_o", {15'b0, sync_o}, 16'h1);
      set_sync_pins(1'b0, 1'b1);
      check_eq("sync_o", {15'b0, sync_o}, 16'h0);
      bus_write(`XDIG_ADDR_SYNC, '0);
      set_sync_pins(1'b0, 1'b1);
      check_eq("sync_o", {15'b0, sync_o}, 16'h1);
      set_sync_pins(1'b1, 1'b0);
      check_eq("sync_o", {15'b0, sync_o}, 16'h0);
      set_sync_pins(1'b0, 1'b0);
      end_test("gen_sync");

      // ------------------------------
      // multiboot sequence
      // ------------------------------
      bus_write(`XDIG_ADDR_MULTIBOOT, 16'h0001);
      cyc = 0;
      while (icap_ce_n_o === 1'b1 && cyc < 10) begin
         @(negedge clk);
         cyc++;
      end
      check_true(icap_ce_n_o === 1'b0, "icap_ce_n_o did not go low after the reboot write");
      nbytes = 0;
      low_len = 0;
      prev_clk = icap_clk_o;
      while (icap_ce_n_o === 1'b0 && low_len < 60) begin
         if (icap_clk_o === 1'b1 && prev_clk === 1'b0) begin
            if (nbytes < `XDIG_ICAP_WORDS)
               check_eq("icap_data_o", {8'h00, icap_data_o},
                        {8'h00, bit_reverse(boot_byte(nbytes))});
            nbytes++;
         end
         prev_clk = icap_clk_o;
         @(negedge clk);
         low_len++;
      end
      check_eq("icap_clk_o rising edges", reg_word_t'(nbytes), reg_word_t'(`XDIG_ICAP_WORDS));
      check_true(low_len <= 40, "icap_ce_n_o stayed low for more than 40 cycles");
      end_test("multiboot");

      $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== xdig.f ====
+incdir+hw
+incdir+tests
hw/xdig_pkg.sv
hw/xdig_regs.sv
hw/trig_filter.sv
hw/trig_router.sv
hw/pulse_gen.sv
hw/irq_latch.sv
hw/sync_select.sv
hw/multiboot_seq.sv
hw/xdig.sv
tests/tb_xdig.sv
